/* logic/id_defines.svh */
`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

//////////////////////////////
// ID space

// Number of instruction IDs and its log
`define ID_MAX_IDS 8
`define ID_LOG2_MAX_IDS 3

//////////////////////////////
// Port counts

// Oldest IDs examined per cycle for retire
`define ID_RETIRE_PORTS 2
// Multi-cycle writeback ports, issue port not included
`define ID_WB_PORTS 1

//////////////////////////////
// Register map

// Byte offsets on the Wishbone slave
`define ID_REG_CTRL 4'h0
`define ID_REG_STATUS 4'h4
`define ID_REG_RETIRED 4'h8

`endif

/* logic/id_pkg.sv */
`include "id_defines.svh"

package id_pkg;

    //////////////////////////////
    // Base types

    // Instruction ID
    typedef logic [`ID_LOG2_MAX_IDS-1:0] id_t;
    // ID count, extra MSB so a full table shows up
    typedef logic [`ID_LOG2_MAX_IDS:0] id_count_t;
    // Instructions retired in one cycle
    typedef logic [$clog2(`ID_RETIRE_PORTS + 1)-1:0] retire_count_t;

    //////////////////////////////
    // Fetch and decode

    // PC sent to fetch with a new ID
    typedef struct packed {
        logic [31:0] pc;
    } fetch_req_t;

    // Fetched word, in assignment order
    typedef struct packed {
        logic        valid;
        logic [31:0] instruction;
    } fetch_rsp_t;

    // Oldest fetched instruction
    typedef struct packed {
        logic        valid;
        id_t         id;
        logic [31:0] pc;
        logic [31:0] instruction;
    } decode_packet_t;

    // Destination info from decode
    typedef struct packed {
        logic       uses_rd;
        logic [4:0] rd_addr;
    } decode_info_t;

    //////////////////////////////
    // Issue, writeback, retire

    typedef struct packed {
        id_t  id;
        logic is_multicycle;
        logic uses_rd;
    } issue_packet_t;

    // Multi-cycle result written back
    typedef struct packed {
        logic valid;
        id_t  id;
    } wb_packet_t;

    // Retired block, at most one rd instruction
    typedef struct packed {
        retire_count_t count;
        logic          valid;
        id_t           phys_id;
    } retire_packet_t;

    // Retire control from the register block
    typedef struct packed {
        logic hold;
        logic single;
    } retire_ctrl_t;

    //////////////////////////////
    // Wishbone classic

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

/* logic/id_toggle_memory.sv */
`timescale 1ns/1ps

module id_toggle_memory #(
    parameter int DEPTH = 8,
    parameter int NUM_WRITE_PORTS = 2,
    parameter int NUM_READ_PORTS = 2
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [NUM_WRITE_PORTS-1:0] toggle,
    input  id_pkg::id_t               toggle_addr [NUM_WRITE_PORTS],
    input  id_pkg::id_t               read_addr [NUM_READ_PORTS],
    output logic [NUM_READ_PORTS-1:0]  in_use
);

    // One bank per write port, so no two ports share a bit
    logic [DEPTH-1:0] bank [NUM_WRITE_PORTS];

    //////////////////////////////
    // Toggle writes

    for (genvar w = 0; w < NUM_WRITE_PORTS; w++) begin : gen_bank
        always_ff @(posedge clk) begin
            if (rst) begin
                bank[w] <= '0;
            end else if (toggle[w]) begin
                // Flip marks waiting on issue, ready on writeback
                bank[w][toggle_addr[w]] <= ~bank[w][toggle_addr[w]];
            end
        end
    end

    //////////////////////////////
    // Reads

    // Set when an odd number of toggles hit the ID
    always_comb begin
        for (int r = 0; r < NUM_READ_PORTS; r++) begin
            in_use[r] = 1'b0;
            for (int w = 0; w < NUM_WRITE_PORTS; w++) begin
                in_use[r] ^= bank[w][read_addr[r]];
            end
        end
    end

endmodule

/* logic/id_allocator.sv */
`timescale 1ns/1ps
`include "id_defines.svh"

module id_allocator (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         fetch_flush,
    output id_pkg::id_t                  pc_id,
    output logic                         pc_id_available,
    input  logic                         pc_id_assigned,
    input  id_pkg::fetch_req_t           fetch_req,
    input  id_pkg::fetch_rsp_t           fetch_rsp,
    output id_pkg::decode_packet_t       decode,
    input  logic                         decode_advance,
    input  id_pkg::decode_info_t         decode_info,
    input  logic                         instruction_issued,
    input  id_pkg::id_count_t            issued_count,
    output id_pkg::id_count_t            post_issue_count,
    output id_pkg::id_count_t            inflight_count,
    input  id_pkg::id_t                  retire_uses_rd_addr [`ID_RETIRE_PORTS],
    output logic [`ID_RETIRE_PORTS-1:0]  retire_uses_rd
);
    import id_pkg::*;

    // Per-ID tables
    logic [31:0] pc_table [`ID_MAX_IDS];
    logic [31:0] instr_table [`ID_MAX_IDS];
    logic        uses_rd_table [`ID_MAX_IDS];

    id_t fetch_id;
    id_t decode_id;
    id_t oldest_pre_issue_id;
    id_t oldest_pre_issue_id_next;

    id_count_t fetched_count_neg;
    id_count_t pre_issue_count;
    id_count_t pre_issue_count_next;
    id_count_t post_issue_count_next;

    //////////////////////////////
    // Tables

    always_ff @(posedge clk) begin
        if (pc_id_assigned) begin
            pc_table[pc_id] <= fetch_req.pc;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_rsp.valid) begin
            instr_table[fetch_id] <= fetch_rsp.instruction;
        end
    end

    // x0 writes are not counted as rd
    always_ff @(posedge clk) begin
        if (decode_advance) begin
            uses_rd_table[decode_id] <= decode_info.uses_rd & |decode_info.rd_addr;
        end
    end

    //////////////////////////////
    // ID pointers

    // Issue consumes IDs strictly in order
    assign oldest_pre_issue_id_next = oldest_pre_issue_id + id_t'(instruction_issued);

    always_ff @(posedge clk) begin
        if (rst) begin
            oldest_pre_issue_id <= '0;
        end else begin
            oldest_pre_issue_id <= oldest_pre_issue_id_next;
        end
    end

    // Flush restarts from the oldest non-issued ID
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_id <= '0;
            fetch_id <= '0;
            decode_id <= '0;
        end else if (fetch_flush) begin
            pc_id <= oldest_pre_issue_id_next;
            fetch_id <= oldest_pre_issue_id_next;
            decode_id <= oldest_pre_issue_id_next;
        end else begin
            pc_id <= pc_id + id_t'(pc_id_assigned);
            fetch_id <= fetch_id + id_t'(fetch_rsp.valid);
            decode_id <= decode_id + id_t'(decode_advance);
        end
    end

    //////////////////////////////
    // Counts

    // Kept negative, MSB set while decode has work
    always_ff @(posedge clk) begin
        if (rst || fetch_flush) begin
            fetched_count_neg <= '0;
        end else begin
            fetched_count_neg <= fetched_count_neg + id_count_t'(decode_advance)
                - id_count_t'(fetch_rsp.valid);
        end
    end

    // Pre-issue part is dropped on flush
    assign pre_issue_count_next = pre_issue_count + id_count_t'(pc_id_assigned)
        - id_count_t'(instruction_issued);

    always_ff @(posedge clk) begin
        if (rst || fetch_flush) begin
            pre_issue_count <= '0;
        end else begin
            pre_issue_count <= pre_issue_count_next;
        end
    end

    // Post-issue part only falls on retire
    assign post_issue_count_next = post_issue_count + id_count_t'(instruction_issued)
        - issued_count;

    always_ff @(posedge clk) begin
        if (rst) begin
            post_issue_count <= '0;
            inflight_count <= '0;
        end else begin
            post_issue_count <= post_issue_count_next;
            if (fetch_flush) begin
                inflight_count <= post_issue_count_next;
            end else begin
                inflight_count <= pre_issue_count_next + post_issue_count_next;
            end
        end
    end

    //////////////////////////////
    // Outputs

    // MSB set means all IDs taken
    assign pc_id_available = ~inflight_count[`ID_LOG2_MAX_IDS];

    assign decode = '{
        valid: fetched_count_neg[`ID_LOG2_MAX_IDS],
        id: decode_id,
        pc: pc_table[decode_id],
        instruction: instr_table[decode_id]
    };

    // rd flags at the retire pointers
    always_comb begin
        for (int i = 0; i < `ID_RETIRE_PORTS; i++) begin
            retire_uses_rd[i] = uses_rd_table[retire_uses_rd_addr[i]];
        end
    end

endmodule

/* logic/id_retirer.sv */
`timescale 1ns/1ps
`include "id_defines.svh"

module id_retirer (
    input  logic                         clk,
    input  logic                         rst,
    input  id_pkg::retire_ctrl_t         ctrl,
    input  id_pkg::id_count_t            post_issue_count,
    output id_pkg::id_t                  retire_ids_next [`ID_RETIRE_PORTS],
    input  logic [`ID_RETIRE_PORTS-1:0]  waiting,
    input  logic [`ID_RETIRE_PORTS-1:0]  uses_rd,
    output id_pkg::retire_packet_t       retire,
    output id_pkg::id_count_t            retire_count_next
);
    import id_pkg::*;

    logic [`ID_RETIRE_PORTS-1:0] port_valid;
    logic                        contiguous;
    logic                        rd_found;
    id_t                         phys_id_next;

    //////////////////////////////
    // Retire pointers

    // Port i trails port 0 by i IDs
    for (genvar i = 0; i < `ID_RETIRE_PORTS; i++) begin : gen_ptr
        always_ff @(posedge clk) begin
            if (rst) begin
                retire_ids_next[i] <= id_t'(i);
            end else begin
                retire_ids_next[i] <= retire_ids_next[i] + id_t'(retire_count_next);
            end
        end
    end

    //////////////////////////////
    // Eligibility chain

    // Block starts at port 0 and stops at the first gap
    // Only one rd writer per block
    always_comb begin
        contiguous = ~ctrl.hold;
        rd_found = 1'b0;
        phys_id_next = retire_ids_next[0];
        for (int i = 0; i < `ID_RETIRE_PORTS; i++) begin
            port_valid[i] = contiguous
                & (post_issue_count > id_count_t'(i))
                & ~waiting[i]
                & ~(uses_rd[i] & rd_found);
            // Priority select of the rd ID
            if (port_valid[i] & uses_rd[i] & ~rd_found) begin
                phys_id_next = retire_ids_next[i];
            end
            rd_found |= port_valid[i] & uses_rd[i];
            // Single mode ends the block after port 0
            contiguous &= port_valid[i] & ~ctrl.single;
        end
    end

    always_comb begin
        retire_count_next = '0;
        for (int i = 0; i < `ID_RETIRE_PORTS; i++) begin
            retire_count_next += id_count_t'(port_valid[i]);
        end
    end

    //////////////////////////////
    // Registered retire packet

    always_ff @(posedge clk) begin
        retire.phys_id <= phys_id_next;
        if (rst) begin
            retire.count <= '0;
            retire.valid <= 1'b0;
        end else begin
            retire.count <= retire_count_t'(retire_count_next);
            retire.valid <= rd_found;
        end
    end

endmodule

/* logic/id_control_regs.sv */
`timescale 1ns/1ps
`include "id_defines.svh"

module id_control_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  id_pkg::wb_req_t         wb_req,
    output id_pkg::wb_rsp_t         wb_rsp,
    output id_pkg::retire_ctrl_t    ctrl,
    input  id_pkg::retire_packet_t  retire,
    input  id_pkg::id_count_t       post_issue_count,
    input  id_pkg::id_count_t       inflight_count
);

    logic        wb_active;
    logic        wb_access;
    logic        ctrl_write;
    logic        retired_clear;
    logic [31:0] retired_count;
    logic [31:0] read_data;

    //////////////////////////////
    // Bus decode

    assign wb_active = wb_req.cyc & wb_req.stb;
    // One access per request, stb stays up during the ack cycle
    assign wb_access = wb_active & ~wb_rsp.ack;

    assign ctrl_write = wb_access & wb_req.we & wb_req.sel[0]
        & (wb_req.adr == `ID_REG_CTRL);
    // Any write to RETIRED clears it
    assign retired_clear = wb_access & wb_req.we & (wb_req.adr == `ID_REG_RETIRED);

    always_comb begin
        case (wb_req.adr)
            `ID_REG_CTRL: read_data = {30'd0, ctrl.single, ctrl.hold};
            `ID_REG_STATUS: read_data = {24'd0, inflight_count, post_issue_count};
            `ID_REG_RETIRED: read_data = retired_count;
            default: read_data = '0;
        endcase
    end

    //////////////////////////////
    // Registers

    // Ack and read data one cycle after the request
    always_ff @(posedge clk) begin
        wb_rsp.dat <= read_data;
        if (rst) begin
            wb_rsp.ack <= 1'b0;
        end else begin
            wb_rsp.ack <= wb_access;
        end
    end

    // Bit 0 hold, bit 1 single
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl <= '0;
        end else if (ctrl_write) begin
            ctrl.hold <= wb_req.dat[0];
            ctrl.single <= wb_req.dat[1];
        end
    end

    // Running total of retired instructions
    always_ff @(posedge clk) begin
        if (rst || retired_clear) begin
            retired_count <= '0;
        end else begin
            retired_count <= retired_count + 32'(retire.count);
        end
    end

endmodule

/* logic/id_manager_top.sv */
`timescale 1ns/1ps
`include "id_defines.svh"

module id_manager_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    fetch_flush,
    output id_pkg::id_t             pc_id,
    output logic                    pc_id_available,
    input  logic                    pc_id_assigned,
    input  id_pkg::fetch_req_t      fetch_req,
    input  id_pkg::fetch_rsp_t      fetch_rsp,
    output id_pkg::decode_packet_t  decode,
    input  logic                    decode_advance,
    input  id_pkg::decode_info_t    decode_info,
    input  logic                    instruction_issued,
    input  id_pkg::issue_packet_t   issue,
    input  id_pkg::wb_packet_t      wb_packet [`ID_WB_PORTS],
    output id_pkg::retire_packet_t  retire,
    input  id_pkg::wb_req_t         wb_req,
    output id_pkg::wb_rsp_t         wb_rsp
);
    import id_pkg::*;

    // Issue port plus the writeback ports
    localparam int TOGGLE_PORTS = `ID_WB_PORTS + 1;

    id_count_t                   post_issue_count;
    id_count_t                   inflight_count;
    id_count_t                   retire_count_next;
    id_t                         retire_ids_next [`ID_RETIRE_PORTS];
    logic [`ID_RETIRE_PORTS-1:0] waiting;
    logic [`ID_RETIRE_PORTS-1:0] uses_rd;
    retire_ctrl_t                ctrl;
    logic [TOGGLE_PORTS-1:0]     waiting_toggle;
    id_t                         waiting_toggle_addr [TOGGLE_PORTS];

    // Port 0 marks multicycle rd writers, the rest clear them
    always_comb begin
        waiting_toggle[0] = instruction_issued & issue.is_multicycle & issue.uses_rd;
        waiting_toggle_addr[0] = issue.id;
        for (int i = 0; i < `ID_WB_PORTS; i++) begin
            waiting_toggle[i + 1] = wb_packet[i].valid;
            waiting_toggle_addr[i + 1] = wb_packet[i].id;
        end
    end

    id_allocator allocator_i (
        .clk(clk),
        .rst(rst),
        .fetch_flush(fetch_flush),
        .pc_id(pc_id),
        .pc_id_available(pc_id_available),
        .pc_id_assigned(pc_id_assigned),
        .fetch_req(fetch_req),
        .fetch_rsp(fetch_rsp),
        .decode(decode),
        .decode_advance(decode_advance),
        .decode_info(decode_info),
        .instruction_issued(instruction_issued),
        .issued_count(retire_count_next),
        .post_issue_count(post_issue_count),
        .inflight_count(inflight_count),
        .retire_uses_rd_addr(retire_ids_next),
        .retire_uses_rd(uses_rd)
    );

    id_toggle_memory #(
        .DEPTH(`ID_MAX_IDS),
        .NUM_WRITE_PORTS(TOGGLE_PORTS),
        .NUM_READ_PORTS(`ID_RETIRE_PORTS)
    ) waiting_mem_i (
        .clk(clk),
        .rst(rst),
        .toggle(waiting_toggle),
        .toggle_addr(waiting_toggle_addr),
        .read_addr(retire_ids_next),
        .in_use(waiting)
    );

    id_retirer retirer_i (
        .clk(clk),
        .rst(rst),
        .ctrl(ctrl),
        .post_issue_count(post_issue_count),
        .retire_ids_next(retire_ids_next),
        .waiting(waiting),
        .uses_rd(uses_rd),
        .retire(retire),
        .retire_count_next(retire_count_next)
    );

    id_control_regs control_regs_i (
        .clk(clk),
        .rst(rst),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp),
        .ctrl(ctrl),
        .retire(retire),
        .post_issue_count(post_issue_count),
        .inflight_count(inflight_count)
    );

endmodule

/* verification/id_manager_chk.sv */
`timescale 1ns/1ps

module id_manager_chk (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pc_id_assigned,
    input  logic                    pc_id_available,
    input  logic                    decode_advance,
    input  id_pkg::decode_packet_t  decode,
    input  id_pkg::wb_req_t         wb_req,
    input  id_pkg::wb_rsp_t         wb_rsp
);

    // Count of broken handshake rules
    int fail_count = 0;

    //////////////////////////////
    // Handshake rules

    // Fetch may only take a free ID
    assign_needs_free_id : assert property (
        @(posedge clk) disable iff (rst) pc_id_assigned |-> pc_id_available
    ) else begin
        $error("pc_id_assigned while no ID was available");
        fail_count++;
    end

    // Decode only consumes a fetched word
    advance_needs_valid : assert property (
        @(posedge clk) disable iff (rst) decode_advance |-> decode.valid
    ) else begin
        $error("decode_advance while decode.valid was low");
        fail_count++;
    end

    // Ack belongs to a live bus cycle
    ack_in_cycle : assert property (
        @(posedge clk) disable iff (rst) wb_rsp.ack |-> (wb_req.cyc && wb_req.stb)
    ) else begin
        $error("Wishbone ack outside an active cycle");
        fail_count++;
    end

endmodule

/* verification/id_manager_tb.sv */
`timescale 1ns/1ps
`include "id_defines.svh"

module id_manager_tb;
    import id_pkg::*;

    // Pipeline entry as fetch, decode and issue see it
    typedef struct packed {
        id_t         id;
        logic [31:0] pc;
        logic [31:0] instr;
        logic        uses_rd;
        logic        mc;
    } pipe_entry_t;

    // Issued ID awaiting retire
    typedef struct packed {
        id_t  id;
        logic waiting;
        logic uses_rd;
    } rob_entry_t;

    logic           clk;
    logic           rst;
    logic           fetch_flush;
    id_t            pc_id;
    logic           pc_id_available;
    logic           pc_id_assigned;
    fetch_req_t     fetch_req;
    fetch_rsp_t     fetch_rsp;
    decode_packet_t decode;
    logic           decode_advance;
    decode_info_t   decode_info;
    logic           instruction_issued;
    issue_packet_t  issue;
    wb_packet_t     wb_packet [`ID_WB_PORTS];
    retire_packet_t retire;
    wb_req_t        wb_req;
    wb_rsp_t        wb_rsp;

    // Model state
    pipe_entry_t    pending_q [$];
    pipe_entry_t    fetched_q [$];
    pipe_entry_t    decoded_q [$];
    rob_entry_t     model_q [$];
    rob_entry_t     issue_entry;
    logic           issue_pend;
    logic           wb_pend;
    id_t            wb_pend_id;
    id_t            next_pc_id;
    id_t            next_issue_id;
    int             pre_cnt;
    logic           model_hold;
    logic           model_single;
    retire_packet_t exp_retire;
    logic [31:0]    retired_total;
    logic [31:0]    rdata;
    logic [31:0]    lfsr;
    logic           do_flush;
    logic           en_assign;
    logic           en_fetch;
    logic           en_decode;
    logic           en_issue;
    logic           en_wb;
    int             error_count;
    int             check_count;
    int             t;

    id_manager_top id_manager_top_i (
        .clk(clk),
        .rst(rst),
        .fetch_flush(fetch_flush),
        .pc_id(pc_id),
        .pc_id_available(pc_id_available),
        .pc_id_assigned(pc_id_assigned),
        .fetch_req(fetch_req),
        .fetch_rsp(fetch_rsp),
        .decode(decode),
        .decode_advance(decode_advance),
        .decode_info(decode_info),
        .instruction_issued(instruction_issued),
        .issue(issue),
        .wb_packet(wb_packet),
        .retire(retire),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp)
    );

    bind id_manager_top id_manager_chk chk_i (
        .clk(clk),
        .rst(rst),
        .pc_id_assigned(pc_id_assigned),
        .pc_id_available(pc_id_available),
        .decode_advance(decode_advance),
        .decode(decode),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////
    // Random source

    // Taps 32 22 2 1
    function automatic logic rand_bit();
        logic b;
        b = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], b};
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], rand_bit()};
        end
        return v;
    endfunction

    //////////////////////////////
    // Reference and compares

    // Oldest issued IDs, stop at a waiting ID or a second rd writer
    function automatic retire_packet_t ref_retire();
        retire_packet_t r;
        int n;
        logic rd;
        r = '0;
        n = 0;
        rd = 1'b0;
        if (!model_hold) begin
            for (int i = 0; i < `ID_RETIRE_PORTS; i++) begin
                if (i >= model_q.size()) break;
                if (model_q[i].waiting) break;
                if (model_q[i].uses_rd && rd) break;
                n++;
                if (model_q[i].uses_rd) begin
                    rd = 1'b1;
                    r.phys_id = model_q[i].id;
                end
                if (model_single) break;
            end
        end
        r.count = retire_count_t'(n);
        r.valid = rd;
        return r;
    endfunction

    task automatic compare_retire(input retire_packet_t got, input retire_packet_t exp);
        check_count++;
        if (got.count !== exp.count || got.valid !== exp.valid
            || (exp.valid && got.phys_id !== exp.phys_id)) begin
            error_count++;
            $display("ERROR %0t: retire count %0d valid %0b id %0d, expected %0d %0b %0d",
                $time, got.count, got.valid, got.phys_id, exp.count, exp.valid, exp.phys_id);
        end
    endtask

    task automatic compare_decode(input decode_packet_t got, input decode_packet_t exp);
        check_count++;
        if (got.valid !== exp.valid || (exp.valid && (got.id !== exp.id
            || got.pc !== exp.pc || got.instruction !== exp.instruction))) begin
            error_count++;
            $display("ERROR %0t: decode valid %0b id %0d pc %h instr %h, expected %0b %0d %h %h",
                $time, got.valid, got.id, got.pc, got.instruction,
                exp.valid, exp.id, exp.pc, exp.instruction);
        end
    endtask

    task automatic compare_reg(input string name, input logic [31:0] got,
        input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR %0t: %s read %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_id(input id_t got, input id_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR %0t: pc_id %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR %0t: %s is %0b, expected %0b", $time, name, got, exp);
        end
    endtask

    task automatic timed_out(input string what);
        $display("Timeout while waiting for %s", what);
        $display("ERRORS FOUND");
        $finish;
    endtask

    //////////////////////////////
    // One cycle of model and stimulus

    task automatic tick();
        decode_packet_t exp_dec;
        pipe_entry_t e;
        logic [4:0] rd;
        logic ur;
        int busy;
        @(negedge clk);
        // Retire registered at the last edge
        compare_retire(retire, exp_retire);
        retired_total += 32'(exp_retire.count);
        // Events committed at the last edge
        if (issue_pend) begin
            model_q.push_back(issue_entry);
            issue_pend = 1'b0;
        end
        if (wb_pend) begin
            foreach (model_q[i]) begin
                if (model_q[i].id == wb_pend_id) model_q[i].waiting = 1'b0;
            end
            wb_pend = 1'b0;
        end
        if (wb_rsp.ack && wb_req.we && wb_req.adr == `ID_REG_CTRL) begin
            model_hold = wb_req.dat[0];
            model_single = wb_req.dat[1];
        end
        exp_dec = '0;
        if (fetched_q.size() > 0) begin
            exp_dec = '{valid: 1'b1, id: fetched_q[0].id, pc: fetched_q[0].pc,
                instruction: fetched_q[0].instr};
        end
        compare_decode(decode, exp_dec);
        // IDs in use after the last edge
        busy = pre_cnt + model_q.size();
        compare_flag("pc_id_available", pc_id_available, busy < `ID_MAX_IDS);
        compare_id(pc_id, next_pc_id);
        // Block for the coming edge
        exp_retire = ref_retire();
        repeat (int'(exp_retire.count)) void'(model_q.pop_front());

        fetch_flush = 1'b0;
        pc_id_assigned = 1'b0;
        fetch_rsp.valid = 1'b0;
        decode_advance = 1'b0;
        instruction_issued = 1'b0;
        wb_packet[0].valid = 1'b0;
        if (do_flush) begin
            // Restart from the oldest non-issued ID
            fetch_flush = 1'b1;
            pending_q.delete();
            fetched_q.delete();
            decoded_q.delete();
            pre_cnt = 0;
            next_pc_id = next_issue_id;
            do_flush = 1'b0;
        end else begin
            if (en_decode && fetched_q.size() > 0 && rand_bit()) begin
                rd = 5'(rand_bits(5));
                ur = rand_bit();
                e = fetched_q.pop_front();
                e.uses_rd = ur && (rd != 5'd0);
                e.mc = rand_bit();
                decoded_q.push_back(e);
                decode_advance = 1'b1;
                decode_info = '{uses_rd: ur, rd_addr: rd};
            end
            if (en_issue && decoded_q.size() > 0 && rand_bit()) begin
                e = decoded_q.pop_front();
                instruction_issued = 1'b1;
                issue = '{id: e.id, is_multicycle: e.mc, uses_rd: e.uses_rd};
                issue_entry = '{id: e.id, waiting: e.mc & e.uses_rd, uses_rd: e.uses_rd};
                issue_pend = 1'b1;
                next_issue_id++;
                pre_cnt--;
            end
            // Fetch answers in assignment order
            if (en_fetch && pending_q.size() > 0 && rand_bit()) begin
                e = pending_q.pop_front();
                e.instr = rand_bits(32);
                fetch_rsp = '{valid: 1'b1, instruction: e.instr};
                fetched_q.push_back(e);
            end
            // New ID only while one is free now
            if (en_assign && busy < `ID_MAX_IDS && rand_bit()) begin
                e = '0;
                e.id = next_pc_id;
                e.pc = rand_bits(32);
                pc_id_assigned = 1'b1;
                fetch_req.pc = e.pc;
                pending_q.push_back(e);
                next_pc_id++;
                pre_cnt++;
            end
            // Random writeback delay per waiting ID
            if (en_wb) begin
                foreach (model_q[i]) begin
                    if (model_q[i].waiting && rand_bits(2) == 0) begin
                        wb_packet[0] = '{valid: 1'b1, id: model_q[i].id};
                        wb_pend = 1'b1;
                        wb_pend_id = model_q[i].id;
                        break;
                    end
                end
            end
        end
    endtask

    //////////////////////////////
    // Wishbone master

    task automatic wb_cycle(input logic we, input logic [3:0] adr, input logic [31:0] dat,
        output logic [31:0] data);
        int n;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat, sel: 4'hf};
        n = 0;
        do begin
            tick();
            n++;
        end while (!wb_rsp.ack && n < 20);
        if (!wb_rsp.ack) timed_out("Wishbone ack");
        data = wb_rsp.dat;
        // Stb held through the ack cycle
        tick();
        wb_req = '0;
    endtask

    task automatic run(input int n);
        repeat (n) tick();
    endtask

    task automatic set_stim(input logic a, input logic f, input logic d, input logic i,
        input logic w);
        en_assign = a;
        en_fetch = f;
        en_decode = d;
        en_issue = i;
        en_wb = w;
    endtask

    //////////////////////////////
    // Sequence

    initial begin
        rst = 1'b1;
        fetch_flush = 1'b0;
        pc_id_assigned = 1'b0;
        fetch_req = '0;
        fetch_rsp = '0;
        decode_advance = 1'b0;
        decode_info = '0;
        instruction_issued = 1'b0;
        issue = '0;
        wb_packet[0] = '0;
        wb_req = '0;
        lfsr = 32'ha937_157c;
        issue_pend = 1'b0;
        wb_pend = 1'b0;
        wb_pend_id = '0;
        issue_entry = '0;
        next_pc_id = '0;
        next_issue_id = '0;
        pre_cnt = 0;
        model_hold = 1'b0;
        model_single = 1'b0;
        exp_retire = '0;
        retired_total = '0;
        do_flush = 1'b0;
        error_count = 0;
        check_count = 0;
        set_stim(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Fill every ID without issuing
        set_stim(1'b1, 1'b1, 1'b1, 1'b0, 1'b0);
        t = 0;
        while (pre_cnt < `ID_MAX_IDS) begin
            tick();
            t++;
            if (t > 300) timed_out("all IDs in flight");
        end
        run(20);

        // Full random traffic
        set_stim(1'b1, 1'b1, 1'b1, 1'b1, 1'b1);
        run(400);

        // Flush with issued IDs still in flight
        do_flush = 1'b1;
        run(200);

        // Hold blocks retire
        wb_cycle(1'b1, `ID_REG_CTRL, 32'h1, rdata);
        run(100);
        set_stim(1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
        run(10);
        wb_cycle(1'b0, `ID_REG_STATUS, 32'h0, rdata);
        compare_reg("STATUS", rdata, {24'd0, 4'(pre_cnt + model_q.size()), 4'(model_q.size())});
        wb_cycle(1'b0, `ID_REG_CTRL, 32'h0, rdata);
        compare_reg("CTRL", rdata, 32'h1);

        // Single retire mode
        wb_cycle(1'b1, `ID_REG_CTRL, 32'h2, rdata);
        set_stim(1'b1, 1'b1, 1'b1, 1'b1, 1'b1);
        run(300);

        // Drain to idle
        wb_cycle(1'b1, `ID_REG_CTRL, 32'h0, rdata);
        set_stim(1'b0, 1'b1, 1'b1, 1'b1, 1'b1);
        t = 0;
        while (pre_cnt != 0 || model_q.size() != 0 || issue_pend) begin
            tick();
            t++;
            if (t > 1000) timed_out("the pipeline to drain");
        end
        run(5);
        wb_cycle(1'b0, `ID_REG_RETIRED, 32'h0, rdata);
        compare_reg("RETIRED", rdata, retired_total);
        wb_cycle(1'b0, `ID_REG_STATUS, 32'h0, rdata);
        compare_reg("STATUS", rdata, 32'h0);
        // Any write clears the counter
        wb_cycle(1'b1, `ID_REG_RETIRED, 32'h0, rdata);
        retired_total = '0;
        wb_cycle(1'b0, `ID_REG_RETIRED, 32'h0, rdata);
        compare_reg("RETIRED", rdata, 32'h0);
        run(5);

        $display("Checks %0d, errors %0d, assertion failures %0d", check_count, error_count,
            id_manager_top_i.chk_i.fail_count);
        if (error_count == 0 && id_manager_top_i.chk_i.fail_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* id_manager_top.f */
+incdir+logic
logic/id_pkg.sv
logic/id_toggle_memory.sv
logic/id_allocator.sv
logic/id_retirer.sv
logic/id_control_regs.sv
logic/id_manager_top.sv
verification/id_manager_chk.sv
verification/id_manager_tb.sv

/* Bender.yml */
package:
  name: id_manager

sources:
  - include_dirs:
      - logic
    files:
      - logic/id_pkg.sv
      - logic/id_toggle_memory.sv
      - logic/id_allocator.sv
      - logic/id_retirer.sv
      - logic/id_control_regs.sv
      - logic/id_manager_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - verification/id_manager_chk.sv
      - verification/id_manager_tb.sv
